// ==== branch_cfg.svh ====
// ==================================================
// build-time sizing for the branch resolution engine
// ==================================================
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// parallel resolver lanes, any value of 1 or more
`define NUM_LANES 4

// data and address width
`define WORD_SIZE 32

// result FIFO entries, power of two
`define RESULT_DEPTH 8

// sequence tag width, wraps
`define TAG_WIDTH 8

`endif

// ==== rv32i_types_pkg.sv ====
// ==================================================
// RV32I word, branch funct3 and B-type instruction types
// ==================================================
`include "branch_cfg.svh"

package rv32i_types_pkg;

  typedef logic [`WORD_SIZE-1:0] word_t;

  // funct3 of the branch group, 010 and 011 left unused
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // B-type field layout, msb first
  typedef struct packed {
    logic       imm12;   // sign bit of offset
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;  // raw, may hold unused codes
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  // one instruction word seen raw or split into fields
  typedef union packed {
    word_t  raw;
    btype_t btype;
  } instr_u;

  localparam logic [6:0] BRANCH_OPCODE = 7'b1100011;

endpackage

// ==== branch_res.sv ====
// ==================================================
// one resolver lane: decode, compare, target, register
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_res (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          issue_valid,
  input  rv32i_types_pkg::word_t        pc,
  input  rv32i_types_pkg::word_t        rs1_data,
  input  rv32i_types_pkg::word_t        rs2_data,
  input  rv32i_types_pkg::instr_u       instr,
  input  logic [`TAG_WIDTH-1:0]         tag,
  output logic                          res_valid,
  output rv32i_types_pkg::word_t        branch_addr,
  output logic                          branch_taken,
  output logic                          branch_illegal,
  output logic [`TAG_WIDTH-1:0]         res_tag
);

  logic [12:0]            imm_sb;   // byte offset, bit 0 always zero
  rv32i_types_pkg::word_t offset;
  logic [`WORD_SIZE:0]    diff;     // one extra bit catches the borrow
  logic                   eq, lt, ltu, sign_1, sign_2, illegal, taken;

  assign imm_sb = {instr.btype.imm12, instr.btype.imm11, instr.btype.imm10_5,
                   instr.btype.imm4_1, 1'b0};
  assign offset = {{(`WORD_SIZE-13){imm_sb[12]}}, imm_sb};

  // single subtractor feeds all three compares
  assign diff   = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign sign_1 = rs1_data[`WORD_SIZE-1];
  assign sign_2 = rs2_data[`WORD_SIZE-1];
  assign eq     = (diff[`WORD_SIZE-1:0] == '0);
  assign ltu    = diff[`WORD_SIZE];  // borrow out
  assign lt     = (sign_1 ^ sign_2) ? sign_1 : diff[`WORD_SIZE-1];  // differing signs decide alone

  assign illegal = (instr.btype.opcode != rv32i_types_pkg::BRANCH_OPCODE) ||
                   (instr.btype.funct3[2:1] == 2'b01);  // codes 010 and 011

  always_comb begin
    case (rv32i_types_pkg::branch_t'(instr.btype.funct3))
      rv32i_types_pkg::BEQ  : taken = eq;
      rv32i_types_pkg::BNE  : taken = ~eq;
      rv32i_types_pkg::BLT  : taken = lt;
      rv32i_types_pkg::BGE  : taken = ~lt;
      rv32i_types_pkg::BLTU : taken = ltu;
      rv32i_types_pkg::BGEU : taken = ~ltu;
      default               : taken = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) res_valid <= 1'b0;
    else        res_valid <= issue_valid;  // result one cycle after issue
  end

  always_ff @(posedge CLK) begin
    if (issue_valid) begin
      branch_addr    <= pc + offset;
      branch_taken   <= taken & ~illegal;  // illegal never taken
      branch_illegal <= illegal;
      res_tag        <= tag;
    end
  end

endmodule

// ==== branch_dispatch.sv ====
// ==================================================
// request holding register, credits, tags, round-robin issue
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_dispatch (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          launch_valid,
  output logic                          launch_ready,
  input  rv32i_types_pkg::word_t        launch_pc,
  input  rv32i_types_pkg::word_t        launch_rs1,
  input  rv32i_types_pkg::word_t        launch_rs2,
  input  rv32i_types_pkg::instr_u       launch_instr,
  input  logic                          credit_return,
  output logic [`NUM_LANES-1:0]         issue_valid,
  output rv32i_types_pkg::word_t        issue_pc,
  output rv32i_types_pkg::word_t        issue_rs1,
  output rv32i_types_pkg::word_t        issue_rs2,
  output rv32i_types_pkg::instr_u       issue_instr,
  output logic [`TAG_WIDTH-1:0]         issue_tag
);

  localparam int LANE_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
  localparam int CNT_W  = $clog2(`RESULT_DEPTH) + 1;

  logic              hold_valid;
  logic              issue;
  logic [LANE_W-1:0] lane_q;   // next lane to receive
  logic [CNT_W-1:0]  credits;  // free FIFO slots not yet claimed

  assign launch_ready = ~hold_valid;
  assign issue        = hold_valid && (credits != '0);

  // strobe only the lane under the pointer
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      issue_valid[i] = issue && (lane_q == LANE_W'(i));
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      lane_q     <= '0;
      credits    <= CNT_W'(`RESULT_DEPTH);
      issue_tag  <= '0;
    end else begin
      if (launch_valid && launch_ready) hold_valid <= 1'b1;
      else if (issue)                   hold_valid <= 1'b0;
      credits <= credits + CNT_W'(credit_return) - CNT_W'(issue);
      if (issue) begin
        issue_tag <= issue_tag + 1'b1;  // wraps by width
        lane_q    <= (lane_q == LANE_W'(`NUM_LANES - 1)) ? '0 : lane_q + 1'b1;
      end
    end
  end

  // held payload drives the shared issue buses directly
  always_ff @(posedge CLK) begin
    if (launch_valid && launch_ready) begin
      issue_pc    <= launch_pc;
      issue_rs1   <= launch_rs1;
      issue_rs2   <= launch_rs2;
      issue_instr <= launch_instr;
    end
  end

endmodule

// ==== branch_collect.sv ====
// ==================================================
// in-order lane drain into the circular result FIFO
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_collect (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic [`NUM_LANES-1:0]         res_valid,
  input  rv32i_types_pkg::word_t        res_target [`NUM_LANES],
  input  logic [`NUM_LANES-1:0]         res_taken,
  input  logic [`NUM_LANES-1:0]         res_illegal,
  input  logic [`TAG_WIDTH-1:0]         res_tag [`NUM_LANES],
  input  logic                          pop,
  output logic [$clog2(`RESULT_DEPTH):0] fifo_count,
  output rv32i_types_pkg::word_t        head_target,
  output logic                          head_taken,
  output logic                          head_illegal,
  output logic [`TAG_WIDTH-1:0]         head_tag,
  output logic                          credit_return
);

  localparam int LANE_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
  localparam int PTR_W  = (`RESULT_DEPTH > 1) ? $clog2(`RESULT_DEPTH) : 1;
  localparam int INFO_W = `TAG_WIDTH + 2;

  logic [LANE_W-1:0]      drain_q;  // mirrors dispatcher pointer
  logic [PTR_W-1:0]       wr_ptr, rd_ptr;
  logic                   push, do_pop;
  rv32i_types_pkg::word_t tgt_mem  [`RESULT_DEPTH];
  logic [INFO_W-1:0]      info_mem [`RESULT_DEPTH];  // {tag, illegal, taken}

  // only the expected lane may write, issue order is kept
  assign push   = res_valid[drain_q];
  assign do_pop = pop && (fifo_count != '0);

  assign credit_return = do_pop;  // slot freed this cycle

  assign head_target  = tgt_mem[rd_ptr];
  assign head_tag     = info_mem[rd_ptr][INFO_W-1:2];
  assign head_illegal = info_mem[rd_ptr][1];
  assign head_taken   = info_mem[rd_ptr][0];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      drain_q    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (push) begin
        drain_q <= (drain_q == LANE_W'(`NUM_LANES - 1)) ? '0 : drain_q + 1'b1;
        wr_ptr  <= (wr_ptr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count + push - do_pop;  // credits keep this bounded
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      tgt_mem[wr_ptr]  <= res_target[drain_q];
      info_mem[wr_ptr] <= {res_tag[drain_q], res_illegal[drain_q], res_taken[drain_q]};
    end
  end

endmodule

// ==== axil_branch_regs.sv ====
// ==================================================
// AXI4-Lite slave with operand regs, launch, status and result pop
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module axil_branch_regs (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          s_awvalid,
  output logic                          s_awready,
  input  logic [7:0]                    s_awaddr,
  input  logic                          s_wvalid,
  output logic                          s_wready,
  input  logic [`WORD_SIZE-1:0]         s_wdata,
  input  logic [3:0]                    s_wstrb,
  output logic                          s_bvalid,
  input  logic                          s_bready,
  output logic [1:0]                    s_bresp,
  input  logic                          s_arvalid,
  output logic                          s_arready,
  input  logic [7:0]                    s_araddr,
  output logic                          s_rvalid,
  input  logic                          s_rready,
  output logic [`WORD_SIZE-1:0]         s_rdata,
  output logic [1:0]                    s_rresp,
  output logic                          launch_valid,
  input  logic                          launch_ready,
  output rv32i_types_pkg::word_t        launch_pc,
  output rv32i_types_pkg::word_t        launch_rs1,
  output rv32i_types_pkg::word_t        launch_rs2,
  output rv32i_types_pkg::instr_u       launch_instr,
  input  logic [$clog2(`RESULT_DEPTH):0] fifo_count,
  input  rv32i_types_pkg::word_t        head_target,
  input  logic                          head_taken,
  input  logic                          head_illegal,
  input  logic [`TAG_WIDTH-1:0]         head_tag,
  output logic                          pop
);

  localparam logic [7:0] ADDR_PC         = 8'h00;
  localparam logic [7:0] ADDR_RS1        = 8'h04;
  localparam logic [7:0] ADDR_RS2        = 8'h08;
  localparam logic [7:0] ADDR_INSTR      = 8'h0C;
  localparam logic [7:0] ADDR_STATUS     = 8'h10;
  localparam logic [7:0] ADDR_RES_TARGET = 8'h14;
  localparam logic [7:0] ADDR_RES_INFO   = 8'h18;
  localparam logic [1:0] RESP_OKAY       = 2'b00;
  localparam logic [1:0] RESP_SLVERR     = 2'b10;

  logic wr_take, wr_hs, wr_mapped, rd_hs;

  // address and data taken together with one write in flight
  assign wr_take   = s_awvalid && s_wvalid && !s_awready && !s_bvalid && !launch_valid;
  assign wr_hs     = s_awvalid && s_awready;  // every write lands as a full word
  assign wr_mapped = (s_awaddr == ADDR_PC) || (s_awaddr == ADDR_RS1) ||
                     (s_awaddr == ADDR_RS2) || (s_awaddr == ADDR_INSTR);
  assign rd_hs     = s_arvalid && s_arready;

  // head leaves the FIFO as its info is captured
  assign pop = rd_hs && (s_araddr == ADDR_RES_INFO) && (fifo_count != '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      s_awready    <= 1'b0;
      s_wready     <= 1'b0;
      s_bvalid     <= 1'b0;
      s_bresp      <= RESP_OKAY;
      launch_valid <= 1'b0;
    end else begin
      s_awready <= wr_take;
      s_wready  <= wr_take;
      if (s_bvalid && s_bready) s_bvalid <= 1'b0;
      if (launch_valid && launch_ready) begin  // response released by the dispatcher
        launch_valid <= 1'b0;
        s_bvalid     <= 1'b1;
        s_bresp      <= RESP_OKAY;
      end
      if (wr_hs) begin
        if (s_awaddr == ADDR_INSTR) begin
          launch_valid <= 1'b1;  // B held back until launch handshake
        end else begin
          s_bvalid <= 1'b1;
          s_bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end
      end
    end
  end

  // operand storage read directly by the launch bus
  always_ff @(posedge CLK) begin
    if (wr_hs) begin
      case (s_awaddr)
        ADDR_PC    : launch_pc        <= s_wdata;
        ADDR_RS1   : launch_rs1       <= s_wdata;
        ADDR_RS2   : launch_rs2       <= s_wdata;
        ADDR_INSTR : launch_instr.raw <= s_wdata;
        default    : ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      s_arready <= s_arvalid && !s_arready && !s_rvalid;
      if (s_rvalid && s_rready) s_rvalid <= 1'b0;
      if (rd_hs)                s_rvalid <= 1'b1;
    end
  end

  // registered read data
  always_ff @(posedge CLK) begin
    if (rd_hs) begin
      s_rresp <= RESP_OKAY;
      case (s_araddr)
        ADDR_PC         : s_rdata <= launch_pc;
        ADDR_RS1        : s_rdata <= launch_rs1;
        ADDR_RS2        : s_rdata <= launch_rs2;
        ADDR_STATUS     : s_rdata <= {23'd0, launch_valid, 8'(fifo_count)};
        ADDR_RES_TARGET : s_rdata <= head_target;
        ADDR_RES_INFO   : begin
          if (fifo_count != '0) begin
            s_rdata <= {16'd0, head_tag, 6'd0, head_illegal, head_taken};
          end else begin
            s_rdata <= '0;  // empty FIFO
            s_rresp <= RESP_SLVERR;
          end
        end
        default         : begin
          s_rdata <= '0;
          s_rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

// ==== branch_res_top.sv ====
// ==================================================
// engine top: AXI slave, dispatcher, lanes, collector
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_res_top (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [7:0]            s_awaddr,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  input  logic [31:0]           s_wdata,
  input  logic [3:0]            s_wstrb,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  output logic [1:0]            s_bresp,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  input  logic [7:0]            s_araddr,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  output logic [31:0]           s_rdata,
  output logic [1:0]            s_rresp
);

  // slave to dispatcher
  logic                         launch_valid, launch_ready;
  rv32i_types_pkg::word_t       launch_pc, launch_rs1, launch_rs2;
  rv32i_types_pkg::instr_u      launch_instr;
  // dispatcher to lanes, shared buses
  logic [`NUM_LANES-1:0]        issue_valid;
  rv32i_types_pkg::word_t       issue_pc, issue_rs1, issue_rs2;
  rv32i_types_pkg::instr_u      issue_instr;
  logic [`TAG_WIDTH-1:0]        issue_tag;
  // lanes to collector
  logic [`NUM_LANES-1:0]        res_valid, res_taken, res_illegal;
  rv32i_types_pkg::word_t       res_target [`NUM_LANES];
  logic [`TAG_WIDTH-1:0]        res_tag [`NUM_LANES];
  // collector to slave and dispatcher
  logic [$clog2(`RESULT_DEPTH):0] fifo_count;
  rv32i_types_pkg::word_t       head_target;
  logic                         head_taken, head_illegal, pop, credit_return;
  logic [`TAG_WIDTH-1:0]        head_tag;

  axil_branch_regs u_regs (
    .CLK, .rst_n,
    .s_awvalid, .s_awready, .s_awaddr, .s_wvalid, .s_wready, .s_wdata, .s_wstrb,
    .s_bvalid, .s_bready, .s_bresp,
    .s_arvalid, .s_arready, .s_araddr, .s_rvalid, .s_rready, .s_rdata, .s_rresp,
    .launch_valid, .launch_ready, .launch_pc, .launch_rs1, .launch_rs2, .launch_instr,
    .fifo_count, .head_target, .head_taken, .head_illegal, .head_tag, .pop
  );

  branch_dispatch u_dispatch (
    .CLK, .rst_n,
    .launch_valid, .launch_ready, .launch_pc, .launch_rs1, .launch_rs2, .launch_instr,
    .credit_return,
    .issue_valid, .issue_pc, .issue_rs1, .issue_rs2, .issue_instr, .issue_tag
  );

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    branch_res u_lane (
      .CLK, .rst_n,
      .issue_valid    (issue_valid[i]),
      .pc             (issue_pc),
      .rs1_data       (issue_rs1),
      .rs2_data       (issue_rs2),
      .instr          (issue_instr),
      .tag            (issue_tag),
      .res_valid      (res_valid[i]),
      .branch_addr    (res_target[i]),
      .branch_taken   (res_taken[i]),
      .branch_illegal (res_illegal[i]),
      .res_tag        (res_tag[i])
    );
  end

  branch_collect u_collect (
    .CLK, .rst_n,
    .res_valid, .res_target, .res_taken, .res_illegal, .res_tag, .pop,
    .fifo_count, .head_target, .head_taken, .head_illegal, .head_tag, .credit_return
  );

endmodule

// ==== tb_branch_tests.svh ====
// ==================================================
// directed tests and branch resolution reference model
// ==================================================

  localparam logic [7:0] REG_PC     = 8'h00;
  localparam logic [7:0] REG_RS1    = 8'h04;
  localparam logic [7:0] REG_RS2    = 8'h08;
  localparam logic [7:0] REG_INSTR  = 8'h0C;
  localparam logic [7:0] REG_STATUS = 8'h10;
  localparam logic [7:0] REG_TARGET = 8'h14;
  localparam logic [7:0] REG_INFO   = 8'h18;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;

  logic [31:0] exp_target_q[$];
  logic [31:0] exp_info_q[$];  // whole RES_INFO word
  logic [7:0]  next_tag = '0;  // tags count from zero per launch
  int          burst_launched;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
  endtask

  // B-type word, rs1 and rs2 fields are don't-care here
  function automatic logic [31:0] enc_branch(input logic [6:0] opcode, input logic [2:0] funct3,
                                             input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, funct3, off[4:1], off[11], opcode};
  endfunction

  task automatic model_branch(input logic [31:0] pc, rs1, rs2, instr,
                              output logic [31:0] target, output logic taken, illegal);
    logic [12:0] imm;
    imm     = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    target  = pc + {{19{imm[12]}}, imm};
    illegal = (instr[6:0] != OP_BRANCH) || (instr[14:13] == 2'b01);  // funct3 010, 011
    case (instr[14:12])
      3'b000  : taken = (rs1 == rs2);
      3'b001  : taken = (rs1 != rs2);
      3'b100  : taken = ($signed(rs1) < $signed(rs2));
      3'b101  : taken = ($signed(rs1) >= $signed(rs2));
      3'b110  : taken = (rs1 < rs2);
      3'b111  : taken = (rs1 >= rs2);
      default : taken = 1'b0;
    endcase
    if (illegal) taken = 1'b0;
  endtask

  task automatic launch(input logic [31:0] pc, rs1, rs2, instr);
    logic [31:0] target;
    logic        taken, illegal;
    logic [1:0]  resp;
    model_branch(pc, rs1, rs2, instr, target, taken, illegal);
    exp_target_q.push_back(target);
    exp_info_q.push_back({16'd0, next_tag, 6'd0, illegal, taken});
    next_tag++;
    axil_write(REG_PC, pc, resp);
    axil_write(REG_RS1, rs1, resp);
    axil_write(REG_RS2, rs2, resp);
    axil_write(REG_INSTR, instr, resp);
    if (resp !== 2'b00) report_mismatch("launch bresp", 32'd0, 32'(resp));
  endtask

  // waits for a non-empty FIFO, then peeks the target and pops the info
  task automatic check_result(input string name);
    logic [31:0] st, target, info;
    logic [1:0]  resp;
    if (exp_target_q.size() == 0) begin
      errors++;
      $display("%s: a result was expected with no launch left to match it", name);
      return;
    end
    do begin
      axil_read(REG_STATUS, st, resp);
    end while (st[7:0] == 8'd0);
    axil_read(REG_TARGET, target, resp);
    if (target !== exp_target_q[0]) report_mismatch({name, " target"}, exp_target_q[0], target);
    axil_read(REG_INFO, info, resp);
    if (info !== exp_info_q[0]) report_mismatch({name, " info"}, exp_info_q[0], info);
    if (resp !== 2'b00) report_mismatch({name, " rresp"}, 32'd0, 32'(resp));
    void'(exp_target_q.pop_front());
    void'(exp_info_q.pop_front());
  endtask

  task automatic regs_and_errors();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(REG_INFO, data, resp);  // nothing launched yet
    if (resp !== 2'b10) report_mismatch("empty info rresp", 32'd2, 32'(resp));
    if (data !== 32'd0) report_mismatch("empty info rdata", 32'd0, data);
    axil_write(REG_PC, 32'h8000_1000, resp);
    axil_write(REG_RS1, 32'hdead_beef, resp);
    axil_write(REG_RS2, 32'h0123_4567, resp);
    axil_write(8'h20, 32'hffff_ffff, resp);
    if (resp !== 2'b10) report_mismatch("unmapped bresp", 32'd2, 32'(resp));
    axil_read(8'h1C, data, resp);
    if (resp !== 2'b10) report_mismatch("unmapped rresp", 32'd2, 32'(resp));
    axil_read(REG_PC, data, resp);
    if (data !== 32'h8000_1000) report_mismatch("pc readback", 32'h8000_1000, data);
    axil_read(REG_RS1, data, resp);
    if (data !== 32'hdead_beef) report_mismatch("rs1 readback", 32'hdead_beef, data);
    axil_read(REG_RS2, data, resp);
    if (data !== 32'h0123_4567) report_mismatch("rs2 readback", 32'h0123_4567, data);
    axil_read(REG_STATUS, data, resp);
    if (data !== 32'd0) report_mismatch("idle status", 32'd0, data);
  endtask

  // six types against equal, sign-crossing and unsigned-crossing pairs
  task automatic branch_types();
    logic [2:0]  f3  [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [12:0] off [6] = '{13'h0008, 13'h1ff0, 13'h0ffe, 13'h1000, 13'h0404, 13'h1f00};
    logic [31:0] a   [3] = '{32'h0000_1234, 32'hffff_fffb, 32'h7fff_ffff};
    logic [31:0] b   [3] = '{32'h0000_1234, 32'h0000_0007, 32'h8000_0000};
    for (int p = 0; p < 3; p++) begin
      for (int t = 0; t < 6; t++) begin
        launch(32'h0001_0000 + 32'(p * 64), a[p], b[p], enc_branch(OP_BRANCH, f3[t], off[t]));
        check_result($sformatf("branch funct3 %0d pair %0d", f3[t], p));
        launch(32'h0001_0000 + 32'(p * 64), b[p], a[p], enc_branch(OP_BRANCH, f3[t], off[t]));
        check_result($sformatf("branch funct3 %0d swapped pair %0d", f3[t], p));
      end
    end
  endtask

  task automatic illegal_codes();
    launch(32'h0000_2000, 32'd5, 32'd5, enc_branch(7'b0010011, 3'b000, 13'h0010));  // op-imm
    check_result("non-branch opcode");
    launch(32'h0000_2000, 32'd5, 32'd5, enc_branch(OP_BRANCH, 3'b010, 13'h0010));
    check_result("funct3 010");
    launch(32'h0000_2000, 32'd1, 32'd9, enc_branch(OP_BRANCH, 3'b011, 13'h1ff8));
    check_result("funct3 011");
  endtask

  task automatic burst_backpressure();
    logic [31:0] st;
    logic [1:0]  resp;
    burst_launched = 0;
    fork
      begin
        for (int i = 0; i < `RESULT_DEPTH + 3; i++) begin
          launch(32'h0000_4000 + 32'(i * 4), 32'(i), 32'h40 - 32'(i),
                 enc_branch(OP_BRANCH, 3'b100, 13'(i * 8)));
          burst_launched++;
        end
      end
      begin
        // full FIFO, one request held, next INSTR write waiting for its response
        do begin
          axil_read(REG_STATUS, st, resp);
        end while (!(st[7:0] == 8'(`RESULT_DEPTH) && st[8] &&
                     burst_launched > `RESULT_DEPTH));
        repeat (40) @(negedge CLK);  // stall must hold
        axil_read(REG_STATUS, st, resp);
        if (st !== {23'd0, 1'b1, 8'(`RESULT_DEPTH)}) begin
          report_mismatch("burst status", {23'd0, 1'b1, 8'(`RESULT_DEPTH)}, st);
        end
        if (burst_launched != `RESULT_DEPTH + 1) begin
          errors++;
          $display("burst: %0d launches completed with a full FIFO, only %0d can",
                   burst_launched, `RESULT_DEPTH + 1);
        end
        for (int i = 0; i < `RESULT_DEPTH + 3; i++) begin
          check_result("burst");
        end
      end
    join
  endtask

  task automatic random_requests();
    logic [31:0] pc, rs1, rs2, instr;
    logic [6:0]  opcode;
    for (int i = 0; i < 200; i++) begin
      pc     = $urandom();
      rs1    = $urandom();
      rs2    = ($urandom_range(0, 3) == 0) ? rs1 : $urandom();  // equal now and then
      opcode = ($urandom_range(0, 7) == 0) ? 7'($urandom()) : OP_BRANCH;
      instr  = enc_branch(opcode, 3'($urandom()), 13'($urandom()));
      launch(pc, rs1, rs2, instr);
      if (exp_target_q.size() >= `RESULT_DEPTH || $urandom_range(0, 2) == 0) begin
        check_result("random");
      end
    end
    while (exp_target_q.size() > 0) begin
      check_result("random drain");
    end
  endtask

// ==== tb_branch_res_top.sv ====
// ==================================================
// testbench top with clock, reset and AXI4-Lite driver tasks
// ==================================================
`timescale 1ns/1ps
`include "branch_cfg.svh"

module tb_branch_res_top;

  // about 250 launches at roughly 25 cycles each plus polling
  localparam int CYCLE_LIMIT = 20000;

  logic        CLK, rst_n;
  logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic        s_arvalid, s_arready, s_rvalid, s_rready;
  logic [7:0]  s_awaddr, s_araddr;
  logic [31:0] s_wdata, s_rdata;
  logic [3:0]  s_wstrb;
  logic [1:0]  s_bresp, s_rresp;
  int          errors;
  int          cycles = 0;

  branch_res_top UUT (
    .CLK, .rst_n,
    .s_awvalid, .s_awready, .s_awaddr, .s_wvalid, .s_wready, .s_wdata, .s_wstrb,
    .s_bvalid, .s_bready, .s_bresp,
    .s_arvalid, .s_arready, .s_araddr, .s_rvalid, .s_rready, .s_rdata, .s_rresp
  );

  always #10 CLK = ~CLK;  // 20 ns period

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors", CYCLE_LIMIT, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // address and data go out together between falling edges
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = 4'hF;  // full word
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    @(negedge CLK);
    while (!(s_awready && s_wready)) @(negedge CLK);  // ready seen here is taken at the next rise
    @(negedge CLK);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid) @(negedge CLK);  // INSTR writes may stall here
    resp = s_bresp;
    @(negedge CLK);
    s_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    @(negedge CLK);
    while (!s_arready) @(negedge CLK);
    @(negedge CLK);
    s_arvalid = 1'b0;
    while (!s_rvalid) @(negedge CLK);
    data = s_rdata;  // stable until the next rise
    resp = s_rresp;
    @(negedge CLK);
    s_rready = 1'b0;
  endtask

  `include "tb_branch_tests.svh"

  initial begin
    CLK       = 1'b0;
    rst_n     = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr  = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = 1'b0;
    s_arvalid = 1'b0;
    s_araddr  = '0;
    s_rready  = 1'b0;
    errors    = 0;
    void'($urandom(32'h6f5f_a0e6));
    repeat (16) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    regs_and_errors();
    branch_types();
    illegal_codes();
    burst_backpressure();
    random_requests();
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== branch_res_top.f ====
+incdir+.
rv32i_types_pkg.sv
branch_res.sv
branch_dispatch.sv
branch_collect.sv
axil_branch_regs.sv
branch_res_top.sv
tb_branch_res_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the branch resolution engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal -f branch_res_top.f \
  --top-module tb_branch_res_top -Mdir "$BUILD" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
